/* hdl/timer_defines.svh */
/*
 * RISC-V style timer, shared defines
 * Bus widths, timer count and the register map offsets
 * of the AHB3-Lite timer slave
 */

`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

// AHB3-Lite bus widths
`define TIMER_HADDR_SIZE 32
`define TIMER_HDATA_SIZE 32
`define TIMER_BE_SIZE 4

// Number of compare timers and width of their index
`define TIMER_COUNT 3
`define TIMER_IDX_SIZE 2

// Register map, byte offsets
`define TIMER_OFS_PRESCALE 32'h00
`define TIMER_OFS_RESERVED 32'h04
`define TIMER_OFS_IPENDING 32'h08
`define TIMER_OFS_IENABLE 32'h0C
`define TIMER_OFS_TIME 32'h10
`define TIMER_OFS_TIME_MSB 32'h14
`define TIMER_OFS_TIMECMP 32'h18

// Compare register n sits at TIMECMP + n * stride
`define TIMER_CMP_STRIDE 8

`endif

/* hdl/timer_pkg.sv */
/*
 * Timer package
 * AHB transfer and size encodings, bus FSM states,
 * register-select opcodes and the byte-lane write merge
 */

`include "timer_defines.svh"

package timer_pkg;

  // AHB HTRANS encoding
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // AHB HSIZE encoding, up to the bus width
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  // Bus slave FSM states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_RD_WAIT,
    ST_RD_DATA
  } bus_state_t;

  // Register selected by the current data phase
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_PRESCALE,
    SEL_IPENDING,
    SEL_IENABLE,
    SEL_TIME_LO,
    SEL_TIME_HI,
    SEL_CMP_LO,
    SEL_CMP_HI
  } reg_sel_t;

  // New byte where its lane is enabled, old byte elsewhere
  function automatic logic [`TIMER_HDATA_SIZE-1:0] merge_bytes(
    input logic [`TIMER_HDATA_SIZE-1:0] old_word,
    input logic [`TIMER_HDATA_SIZE-1:0] new_word,
    input logic [`TIMER_BE_SIZE-1:0]    be
  );
    logic [`TIMER_HDATA_SIZE-1:0] result;
    for (int n = 0; n < `TIMER_BE_SIZE; n++)
    begin
      result[n*8 +: 8] = be[n] ? new_word[n*8 +: 8] : old_word[n*8 +: 8];
    end
    return result;
  endfunction

endpackage

/* hdl/timer_bus_fsm.sv */
/*
 * Timer AHB3-Lite slave FSM
 * Captures the address phase of accepted transfers, decodes the
 * register select, timer index and byte lanes, and inserts the
 * single read wait state through HREADYOUT
 */

`timescale 1ns/100ps

`include "timer_defines.svh"

module timer_bus_fsm
  import timer_pkg::*;
(
  input  logic                         HCLK,
  input  logic                         HRESETn,
  input  logic                         HSEL,
  input  logic [`TIMER_HADDR_SIZE-1:0] HADDR,
  input  logic                         HWRITE,
  input  hsize_t                       HSIZE,
  input  htrans_t                      HTRANS,
  input  logic                         HREADY,
  output logic                         HREADYOUT,
  output logic                         wr_strobe,
  output reg_sel_t                     reg_sel,
  output logic [`TIMER_IDX_SIZE-1:0]   cmp_idx,
  output logic [`TIMER_BE_SIZE-1:0]    byte_en
);

  // Compare block spans TIMER_COUNT strides from TIMECMP
  localparam int CMP_SHIFT = $clog2(`TIMER_CMP_STRIDE);
  localparam logic [`TIMER_HADDR_SIZE-1:0] CMP_END =
    `TIMER_OFS_TIMECMP + `TIMER_COUNT * `TIMER_CMP_STRIDE;

  bus_state_t                   state;
  bus_state_t                   state_nxt;
  logic                         accept;
  logic                         phase_end;
  logic [`TIMER_HADDR_SIZE-1:0] word_addr;
  logic [`TIMER_HADDR_SIZE-1:0] cmp_ofs;
  reg_sel_t                     dec_sel;
  logic [`TIMER_IDX_SIZE-1:0]   dec_idx;
  logic [`TIMER_BE_SIZE-1:0]    dec_be;

  //////////////////////////////////////////////////
  // Address phase decode
  //////////////////////////////////////////////////

  // Valid transfer on this edge, BUSY and IDLE ignored
  assign accept = HREADY & HSEL & ((HTRANS == HTRANS_NONSEQ) | (HTRANS == HTRANS_SEQ));

  // Word aligned offset, lane bits go to byte_en
  assign word_addr = {HADDR[`TIMER_HADDR_SIZE-1:2], 2'b00};
  assign cmp_ofs   = word_addr - `TIMER_OFS_TIMECMP;

  always_comb
  begin
    dec_idx = cmp_ofs[CMP_SHIFT +: `TIMER_IDX_SIZE];
    case (word_addr)
      `TIMER_OFS_PRESCALE: dec_sel = SEL_PRESCALE;
      `TIMER_OFS_IPENDING: dec_sel = SEL_IPENDING;
      `TIMER_OFS_IENABLE:  dec_sel = SEL_IENABLE;
      `TIMER_OFS_TIME:     dec_sel = SEL_TIME_LO;
      `TIMER_OFS_TIME_MSB: dec_sel = SEL_TIME_HI;
      // Reserved word, nothing behind it
      `TIMER_OFS_RESERVED: dec_sel = SEL_NONE;
      default:
      begin
        // Compare words, anything else is off the map
        if (word_addr >= `TIMER_OFS_TIMECMP && word_addr < CMP_END)
        begin
          dec_sel = word_addr[2] ? SEL_CMP_HI : SEL_CMP_LO;
        end
        else
        begin
          dec_sel = SEL_NONE;
        end
      end
    endcase
  end

  // Byte lanes from size and low address bits
  always_comb
  begin
    case (HSIZE)
      HSIZE_BYTE:  dec_be = 4'b0001 << HADDR[1:0];
      HSIZE_HWORD: dec_be = 4'b0011 << {HADDR[1], 1'b0};
      default:     dec_be = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////
  // Data phase FSM
  //////////////////////////////////////////////////

  // Data phase finishes when the master sees HREADY
  always_comb
  begin
    case (state)
      ST_IDLE:    phase_end = 1'b1;
      ST_RD_WAIT: phase_end = 1'b0;
      default:    phase_end = HREADY;
    endcase
  end

  always_comb
  begin
    if (state == ST_RD_WAIT)
    begin
      state_nxt = ST_RD_DATA;
    end
    else if (!phase_end)
    begin
      state_nxt = state;
    end
    else if (accept)
    begin
      state_nxt = HWRITE ? ST_WRITE : ST_RD_WAIT;
    end
    else
    begin
      state_nxt = ST_IDLE;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state   <= ST_IDLE;
      reg_sel <= SEL_NONE;
      cmp_idx <= '0;
      byte_en <= '0;
    end
    else
    begin
      state <= state_nxt;
      // Hold address info for the whole data phase
      if (phase_end && accept)
      begin
        reg_sel <= dec_sel;
        cmp_idx <= dec_idx;
        byte_en <= dec_be;
      end
    end
  end

  // Write takes effect at the edge closing the data phase
  assign wr_strobe = (state == ST_WRITE) & HREADY;

  // One wait state on reads
  assign HREADYOUT = (state != ST_RD_WAIT);

endmodule

/* hdl/timer_counter.sv */
/*
 * Timer prescaler and time counter
 * First prescale write enables counting, then the 64-bit
 * time advances once every prescale + 1 cycles
 */

`timescale 1ns/100ps

`include "timer_defines.svh"

module timer_counter
  import timer_pkg::*;
(
  input  logic                         HCLK,
  input  logic                         HRESETn,
  input  logic [`TIMER_HDATA_SIZE-1:0] HWDATA,
  input  logic                         wr_strobe,
  input  reg_sel_t                     reg_sel,
  input  logic [`TIMER_BE_SIZE-1:0]    byte_en,
  output logic [`TIMER_HDATA_SIZE-1:0] prescale,
  output logic                         enabled,
  output logic [63:0]                  mtime
);

  logic                         prescale_wr;
  logic [`TIMER_HDATA_SIZE-1:0] prescale_nxt;
  logic [`TIMER_HDATA_SIZE-1:0] prescale_cnt;
  logic                         count_en;

  assign prescale_wr  = wr_strobe & (reg_sel == SEL_PRESCALE);
  assign prescale_nxt = merge_bytes(prescale, HWDATA, byte_en);

  //////////////////////////////////////////////////
  // Prescaler
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prescale     <= '0;
      enabled      <= 1'b0;
      prescale_cnt <= '0;
      count_en     <= 1'b0;
    end
    else
    begin
      // Down counter reloads on write and on reaching zero
      if (prescale_wr)
      begin
        prescale     <= prescale_nxt;
        enabled      <= 1'b1;
        prescale_cnt <= prescale_nxt;
      end
      else if (prescale_cnt == '0)
      begin
        prescale_cnt <= prescale;
      end
      else
      begin
        prescale_cnt <= prescale_cnt - 1'b1;
      end
      // One pulse per prescale period
      count_en <= enabled & (prescale_cnt == '0);
    end
  end

  //////////////////////////////////////////////////
  // Time register
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      mtime <= '0;
    end
    else if (wr_strobe && reg_sel == SEL_TIME_LO)
    begin
      mtime[31:0] <= merge_bytes(mtime[31:0], HWDATA, byte_en);
    end
    else if (wr_strobe && reg_sel == SEL_TIME_HI)
    begin
      mtime[63:32] <= merge_bytes(mtime[63:32], HWDATA, byte_en);
    end
    else if (count_en)
    begin
      mtime <= mtime + 64'd1;
    end
  end

endmodule

/* hdl/timer_regs.sv */
/*
 * Timer register bank
 * Per-timer compare registers, interrupt pending and enable,
 * the registered interrupt output and the read data mux
 */

`timescale 1ns/100ps

`include "timer_defines.svh"

module timer_regs
  import timer_pkg::*;
(
  input  logic                         HCLK,
  input  logic                         HRESETn,
  input  logic [`TIMER_HDATA_SIZE-1:0] HWDATA,
  input  logic                         wr_strobe,
  input  reg_sel_t                     reg_sel,
  input  logic [`TIMER_IDX_SIZE-1:0]   cmp_idx,
  input  logic [`TIMER_BE_SIZE-1:0]    byte_en,
  input  logic [`TIMER_HDATA_SIZE-1:0] prescale,
  input  logic                         enabled,
  input  logic [63:0]                  mtime,
  output logic [`TIMER_HDATA_SIZE-1:0] HRDATA,
  output logic                         tint
);

  localparam int IDX_W = `TIMER_IDX_SIZE;

  logic [63:0]                  timecmp [`TIMER_COUNT];
  logic [`TIMER_COUNT-1:0]      ipending;
  logic [`TIMER_COUNT-1:0]      ienable;
  logic [`TIMER_HDATA_SIZE-1:0] ipending_rd;
  logic [`TIMER_HDATA_SIZE-1:0] ienable_rd;
  logic [`TIMER_HDATA_SIZE-1:0] ienable_nxt;
  logic [63:0]                  cmp_sel;
  logic [`TIMER_HDATA_SIZE-1:0] rd_data;
  logic                         cmp_wr;

  // Unused upper bits read as zero
  assign ipending_rd = {{(`TIMER_HDATA_SIZE-`TIMER_COUNT){1'b0}}, ipending};
  assign ienable_rd  = {{(`TIMER_HDATA_SIZE-`TIMER_COUNT){1'b0}}, ienable};
  assign ienable_nxt = merge_bytes(ienable_rd, HWDATA, byte_en);

  assign cmp_wr = wr_strobe & ((reg_sel == SEL_CMP_LO) | (reg_sel == SEL_CMP_HI));

  //////////////////////////////////////////////////
  // Compare and pending
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      for (int n = 0; n < `TIMER_COUNT; n++)
      begin
        timecmp[n] <= '0;
      end
      ipending <= '0;
    end
    else
    begin
      for (int n = 0; n < `TIMER_COUNT; n++)
      begin
        if (cmp_wr && cmp_idx == IDX_W'(n))
        begin
          // Writing either half rearms the timer
          if (reg_sel == SEL_CMP_HI)
          begin
            timecmp[n][63:32] <= merge_bytes(timecmp[n][63:32], HWDATA, byte_en);
          end
          else
          begin
            timecmp[n][31:0] <= merge_bytes(timecmp[n][31:0], HWDATA, byte_en);
          end
          ipending[n] <= 1'b0;
        end
        else
        begin
          // Sticky until the next compare write
          ipending[n] <= ipending[n] | (enabled & (timecmp[n] <= mtime));
        end
      end
    end
  end

  // Interrupt enable, only implemented bits kept
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      ienable <= '0;
    end
    else if (wr_strobe && reg_sel == SEL_IENABLE)
    begin
      ienable <= ienable_nxt[`TIMER_COUNT-1:0];
    end
  end

  //////////////////////////////////////////////////
  // Interrupt output
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      tint <= 1'b0;
    end
    else
    begin
      tint <= |(ipending & ienable);
    end
  end

  //////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////

  // Compare register picked by the data phase index
  always_comb
  begin
    cmp_sel = '0;
    for (int n = 0; n < `TIMER_COUNT; n++)
    begin
      if (cmp_idx == IDX_W'(n))
      begin
        cmp_sel = timecmp[n];
      end
    end
  end

  always_comb
  begin
    case (reg_sel)
      SEL_PRESCALE: rd_data = prescale;
      SEL_IPENDING: rd_data = ipending_rd;
      SEL_IENABLE:  rd_data = ienable_rd;
      SEL_TIME_LO:  rd_data = mtime[31:0];
      SEL_TIME_HI:  rd_data = mtime[63:32];
      SEL_CMP_LO:   rd_data = cmp_sel[31:0];
      SEL_CMP_HI:   rd_data = cmp_sel[63:32];
      // Reserved and off-map words
      default:      rd_data = '0;
    endcase
  end

  // Valid in the second read cycle
  always_ff @(posedge HCLK)
  begin
    HRDATA <= rd_data;
  end

endmodule

/* hdl/ahb3lite_timer.sv */
/*
 * AHB3-Lite timer, top level
 * RISC-V style 64-bit time counter with per-timer compare
 * registers and one shared interrupt output
 */

`timescale 1ns/100ps

`include "timer_defines.svh"

module ahb3lite_timer
  import timer_pkg::*;
(
  input  logic                         HCLK,
  input  logic                         HRESETn,
  input  logic                         HSEL,
  input  logic [`TIMER_HADDR_SIZE-1:0] HADDR,
  input  logic [`TIMER_HDATA_SIZE-1:0] HWDATA,
  input  logic                         HWRITE,
  input  hsize_t                       HSIZE,
  input  htrans_t                      HTRANS,
  input  logic                         HREADY,
  output logic [`TIMER_HDATA_SIZE-1:0] HRDATA,
  output logic                         HREADYOUT,
  output logic                         HRESP,
  output logic                         tint
);

  logic                         wr_strobe;
  reg_sel_t                     reg_sel;
  logic [`TIMER_IDX_SIZE-1:0]   cmp_idx;
  logic [`TIMER_BE_SIZE-1:0]    byte_en;
  logic [`TIMER_HDATA_SIZE-1:0] prescale;
  logic                         enabled;
  logic [63:0]                  mtime;

  // Always OKAY
  assign HRESP = 1'b0;

  // Bus side
  timer_bus_fsm u_bus_fsm (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT),
    .wr_strobe (wr_strobe),
    .reg_sel   (reg_sel),
    .cmp_idx   (cmp_idx),
    .byte_en   (byte_en)
  );

  // Prescaler and time
  timer_counter u_counter (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HWDATA    (HWDATA),
    .wr_strobe (wr_strobe),
    .reg_sel   (reg_sel),
    .byte_en   (byte_en),
    .prescale  (prescale),
    .enabled   (enabled),
    .mtime     (mtime)
  );

  // Compare, interrupt and read back
  timer_regs u_regs (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HWDATA    (HWDATA),
    .wr_strobe (wr_strobe),
    .reg_sel   (reg_sel),
    .cmp_idx   (cmp_idx),
    .byte_en   (byte_en),
    .prescale  (prescale),
    .enabled   (enabled),
    .mtime     (mtime),
    .HRDATA    (HRDATA),
    .tint      (tint)
  );

endmodule

/* sim/timer_assertions.sv */
/*
 * Timer bus and interrupt assertions
 * Bound into the timer top level, watches HRESP,
 * the read wait state and tint during reset
 */

`timescale 1ns/100ps

module timer_assertions (
  input logic HCLK,
  input logic HRESETn,
  input logic HREADYOUT,
  input logic HRESP,
  input logic tint
);

  // Failure count, read by the testbench at the end
  int fail_count = 0;

  // Slave never signals ERROR
  a_hresp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn) HRESP == 1'b0)
    else
    begin
      fail_count++;
      $error("HRESP left OKAY");
    end

  // Only one wait state per read
  a_one_wait: assert property (@(posedge HCLK) disable iff (!HRESETn) !HREADYOUT |=> HREADYOUT)
    else
    begin
      fail_count++;
      $error("HREADYOUT low for two cycles");
    end

  // Interrupt held off in reset
  a_tint_reset: assert property (@(posedge HCLK) !HRESETn |-> !tint)
    else
    begin
      fail_count++;
      $error("tint high during reset");
    end

endmodule

bind ahb3lite_timer timer_assertions u_assertions (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .HREADYOUT (HREADYOUT),
  .HRESP     (HRESP),
  .tint      (tint)
);

/* sim/timer_checker.sv */
/*
 * Timer bus checker
 * Snoops the AHB3-Lite port, shadows prescale, ienable and the
 * compare registers, checks read data and the idle interrupt
 */

`timescale 1ns/100ps

`include "timer_defines.svh"

module timer_checker (
  input logic        HCLK,
  input logic        HRESETn,
  input logic        HSEL,
  input logic [31:0] HADDR,
  input logic [31:0] HWDATA,
  input logic        HWRITE,
  input logic [2:0]  HSIZE,
  input logic [1:0]  HTRANS,
  input logic        HREADY,
  input logic [31:0] HRDATA,
  input logic        tint
);

  int          err_count = 0;
  logic [31:0] sh_prescale;
  logic [31:0] sh_ien;
  logic [31:0] sh_cmp [6];
  logic        pend;
  logic        pend_wr;
  logic [31:0] pend_addr;
  logic [3:0]  pend_be;
  logic [31:0] exp_data;
  logic        known;
  int          quiet;

  // Byte-lane write rule
  function automatic logic [31:0] merge_ref(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input logic [3:0] be);
    logic [31:0] res;
    for (int n = 0; n < 4; n++)
    begin
      res[n*8 +: 8] = be[n] ? new_w[n*8 +: 8] : old_w[n*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic [3:0] lanes(input logic [2:0] sz, input logic [1:0] lo);
    if (sz == 3'd0)
      return 4'b0001 << lo;
    else if (sz == 3'd1)
      return lo[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  function automatic bit is_cmp(input logic [31:0] a);
    return a >= `TIMER_OFS_TIMECMP && a < `TIMER_OFS_TIMECMP + 8 * `TIMER_COUNT;
  endfunction

  //////////////////////////////////////////////////
  // Sampled just after the falling edge, all stable
  //////////////////////////////////////////////////
  always
  begin
    @(negedge HCLK);
    #1;
    if (!HRESETn)
    begin
      sh_prescale = '0;
      sh_ien      = '0;
      foreach (sh_cmp[i])
        sh_cmp[i] = '0;
      pend  = 1'b0;
      quiet = 0;
    end
    else
    begin
      // Data phase ends at the coming edge
      if (pend && HREADY)
      begin
        pend = 1'b0;
        if (pend_wr)
        begin
          if (pend_addr == `TIMER_OFS_PRESCALE)
            sh_prescale = merge_ref(sh_prescale, HWDATA, pend_be);
          else if (pend_addr == `TIMER_OFS_IENABLE)
            sh_ien = merge_ref(sh_ien, HWDATA, pend_be) & ((32'd1 << `TIMER_COUNT) - 1);
          else if (is_cmp(pend_addr))
            sh_cmp[(pend_addr - `TIMER_OFS_TIMECMP) >> 2] =
              merge_ref(sh_cmp[(pend_addr - `TIMER_OFS_TIMECMP) >> 2], HWDATA, pend_be);
        end
        else
        begin
          known    = 1'b1;
          exp_data = '0;
          // Time and pending move on their own
          if (pend_addr == `TIMER_OFS_PRESCALE)
            exp_data = sh_prescale;
          else if (pend_addr == `TIMER_OFS_IENABLE)
            exp_data = sh_ien;
          else if (is_cmp(pend_addr))
            exp_data = sh_cmp[(pend_addr - `TIMER_OFS_TIMECMP) >> 2];
          else if (pend_addr == `TIMER_OFS_IPENDING || pend_addr == `TIMER_OFS_TIME ||
                   pend_addr == `TIMER_OFS_TIME_MSB)
            known = 1'b0;
          if (known && HRDATA !== exp_data)
          begin
            err_count++;
            $display("Mismatch at %0t: HRDATA (addr %h) got %h expected %h",
                     $time, pend_addr, HRDATA, exp_data);
          end
        end
      end
      // New address phase
      if (HREADY && HSEL && HTRANS[1])
      begin
        pend      = 1'b1;
        pend_wr   = HWRITE;
        pend_addr = {HADDR[31:2], 2'b00};
        pend_be   = lanes(HSIZE, HADDR[1:0]);
      end
      // All enables off, tint must settle low
      quiet = (sh_ien == 0) ? quiet + 1 : 0;
      if (quiet > 2 && tint)
      begin
        err_count++;
        $display("Interrupt raised at %0t while every enable bit is clear", $time);
      end
    end
  end

endmodule

/* sim/tb_ahb3lite_timer.sv */
/*
 * AHB3-Lite timer testbench
 * Clock, reset, LCG stimulus, bus tasks and the test sequence
 */

`timescale 1ns/100ps

`include "timer_defines.svh"

module tb_ahb3lite_timer
  import timer_pkg::*;
;

  logic        HCLK = 1'b0;
  logic        HRESETn;
  logic        HSEL;
  logic [31:0] HADDR;
  logic [31:0] HWDATA;
  logic        HWRITE;
  hsize_t      HSIZE;
  htrans_t     HTRANS;
  logic        HREADY;
  logic [31:0] HRDATA;
  logic        HREADYOUT;
  logic        HRESP;
  logic        tint;
  int          seq_errors = 0;
  int          cycle = 0;
  int          c0;
  int          ticks;
  int          sz;
  logic [31:0] lcg_state;
  logic [31:0] r;
  logic [31:0] rd;
  logic [31:0] t;
  logic [31:0] base;
  logic [31:0] odd_addr [4] = '{32'h08, 32'h04, 32'h30, 32'h100};

  always #2 HCLK = ~HCLK;

  always @(posedge HCLK)
    cycle <= cycle + 1;

  // Single slave so HREADY loops back
  assign HREADY = HREADYOUT;

  ahb3lite_timer dut0 (.*);

  timer_checker chk0 (.HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR),
    .HWDATA(HWDATA), .HWRITE(HWRITE), .HSIZE(HSIZE), .HTRANS(HTRANS), .HREADY(HREADY),
    .HRDATA(HRDATA), .tint(tint));

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic print_counts();
    $display("Errors: checker %0d, sequence %0d, assertions %0d",
             chk0.err_count, seq_errors, dut0.u_assertions.fail_count);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    print_counts();
    $display("Test FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      seq_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // HREADY seen at the falling edge
  task automatic wait_ready();
    int n;
    n = 0;
    while (!HREADY)
    begin
      @(negedge HCLK);
      n++;
      if (n > 100)
        abort_run("Timeout waiting for HREADYOUT");
    end
  endtask

  task automatic wait_tint(input logic level);
    int n;
    n = 0;
    while (tint !== level)
    begin
      @(negedge HCLK);
      n++;
      if (n > 2000)
        abort_run("Timeout waiting for tint to change");
    end
  endtask

  // One transfer with its address and data phase
  task automatic bus_xfer(input logic wr, input logic [31:0] addr, input int size,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge HCLK);
    HSEL   = 1'b1;
    HADDR  = addr;
    HWRITE = wr;
    HSIZE  = hsize_t'(size);
    HTRANS = HTRANS_NONSEQ;
    wait_ready();
    @(negedge HCLK);
    HSEL   = 1'b0;
    HWRITE = 1'b0;
    HTRANS = HTRANS_IDLE;
    if (wr)
      HWDATA = wdata;
    wait_ready();
    rdata = HRDATA;
  endtask

  task automatic write_reg(input logic [31:0] addr, input int size, input logic [31:0] data);
    logic [31:0] dummy;
    bus_xfer(1'b1, addr, size, data, dummy);
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    bus_xfer(1'b0, addr, 2, '0, data);
  endtask

  initial
  begin
    lcg_state = 32'h18353d90;
    HRESETn = 1'b0;
    HSEL    = 1'b0;
    HADDR   = '0;
    HWDATA  = '0;
    HWRITE  = 1'b0;
    HSIZE   = HSIZE_WORD;
    HTRANS  = HTRANS_IDLE;
    repeat (5) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);

    // Reset state
    check_value("tint", {31'b0, tint}, 32'd0);
    check_value("HREADYOUT", {31'b0, HREADYOUT}, 32'd1);
    for (int a = 0; a < 32'h30; a += 4)
    begin
      read_reg(a, rd);
      check_value("HRDATA", rd, 32'd0);
    end

    // Random sized writes checked on read back by the checker
    repeat (24)
    begin
      r    = lcg_next();
      base = (r[2:0] % 7 == 0) ? `TIMER_OFS_IENABLE : `TIMER_OFS_TIMECMP + (r[2:0] % 7 - 1) * 4;
      sz   = r[4:3] % 3;
      t    = (sz == 0) ? r[6:5] : (sz == 1) ? {r[6], 1'b0} : 0;
      write_reg(base + t, sz, lcg_next());
      read_reg(base, rd);
    end
    // Pending, reserved and off-map words ignore writes
    foreach (odd_addr[i])
    begin
      write_reg(odd_addr[i], 2, lcg_next());
      read_reg(odd_addr[i], rd);
      check_value("HRDATA", rd, 32'd0);
    end
    // Whole map unchanged by the stray writes
    for (int a = 0; a < 32'h30; a += 4)
    begin
      read_reg(a, rd);
      if (a == `TIMER_OFS_IPENDING || a == `TIMER_OFS_TIME || a == `TIMER_OFS_TIME_MSB)
        check_value("HRDATA", rd, 32'd0);
    end

    // No counting before the prescale write
    read_reg(`TIMER_OFS_TIME, t);
    repeat (50) @(negedge HCLK);
    read_reg(`TIMER_OFS_TIME, rd);
    check_value("time", rd, t);

    // Park every compare far away and start with P = 3
    for (int n = 0; n < 2 * `TIMER_COUNT; n++)
      write_reg(`TIMER_OFS_TIMECMP + n * 4, 2, 32'hFFFF_FFFF);
    write_reg(`TIMER_OFS_PRESCALE, 2, 32'd3);
    write_reg(`TIMER_OFS_TIME_MSB, 2, 32'd0);
    write_reg(`TIMER_OFS_TIME, 2, 32'd0);
    c0 = cycle;
    repeat (200) @(negedge HCLK);
    read_reg(`TIMER_OFS_TIME, rd);
    ticks = (cycle - c0) / 4;
    if (int'(rd) < ticks - 2 || int'(rd) > ticks + 2)
    begin
      seq_errors++;
      $display("Mismatch at %0t: time got %0d expected %0d +/- 2", $time, rd, ticks);
    end
    r = lcg_next();
    write_reg(`TIMER_OFS_TIME_MSB, 2, r);
    read_reg(`TIMER_OFS_TIME_MSB, rd);
    check_value("time_msb", rd, r);
    write_reg(`TIMER_OFS_TIME_MSB, 2, 32'd0);

    // Each timer fires and is cleared by a compare write
    for (int n = 0; n < `TIMER_COUNT; n++)
    begin
      base = `TIMER_OFS_TIMECMP + n * `TIMER_CMP_STRIDE;
      read_reg(`TIMER_OFS_TIME, t);
      write_reg(base + 4, 2, 32'd0);
      write_reg(base, 2, t + 32'd20);
      write_reg(`TIMER_OFS_IENABLE, 2, 32'd1 << n);
      wait_tint(1'b1);
      read_reg(`TIMER_OFS_IPENDING, rd);
      check_value("ipending", rd, 32'd1 << n);
      write_reg(base, 2, 32'hFFFF_FFFF);
      write_reg(base + 4, 2, 32'hFFFF_FFFF);
      wait_tint(1'b0);
      read_reg(`TIMER_OFS_IPENDING, rd);
      check_value("ipending", rd, 32'd0);
    end

    // Masked timer sets pending without an interrupt
    write_reg(`TIMER_OFS_IENABLE, 2, 32'd0);
    read_reg(`TIMER_OFS_TIME, t);
    write_reg(`TIMER_OFS_TIMECMP + 4, 2, 32'd0);
    write_reg(`TIMER_OFS_TIMECMP, 2, t + 32'd10);
    rd = '0;
    c0 = 0;
    while (rd[0] !== 1'b1)
    begin
      read_reg(`TIMER_OFS_IPENDING, rd);
      check_value("tint", {31'b0, tint}, 32'd0);
      c0++;
      if (c0 > 200)
        abort_run("Timeout waiting for pending bit of timer 0");
    end
    check_value("ipending", rd, 32'd1);

    repeat (5) @(negedge HCLK);
    print_counts();
    if (chk0.err_count == 0 && seq_errors == 0 && dut0.u_assertions.fail_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* ahb3lite_timer.f */
+incdir+hdl
hdl/timer_pkg.sv
hdl/timer_bus_fsm.sv
hdl/timer_counter.sv
hdl/timer_regs.sv
hdl/ahb3lite_timer.sv
sim/timer_assertions.sv
sim/timer_checker.sv
sim/tb_ahb3lite_timer.sv

/* Makefile */
# Verilator build and run of the AHB3-Lite timer testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --assert -Wno-fatal -j 0
TOP       ?= tb_ahb3lite_timer
FILELIST  ?= ahb3lite_timer.f

SOURCES := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
